//--- include/lockstep_consts.svh
/*
 * Lockstep subsystem constants
 * Bus widths, program shape of the cores and error-counter size
 */

`ifndef LOCKSTEP_CONSTS_SVH
`define LOCKSTEP_CONSTS_SVH

// Wishbone bus widths
`define LS_ADDR_W 32
`define LS_DATA_W 32

// Reads accumulated before each store of the running sum
`define LS_BURST_LEN 4

// Byte address that receives every stored sum
`define LS_RESULT_ADDR 32'h0000_1000

// Mismatch counter saturates at its all-ones value
`define LS_ERRCNT_W 8

`endif

//--- hw/lockstep_pkg.sv
/*
 * Lockstep package
 * Vector types, Wishbone classic request/response structs and core FSM states
 */

package lockstep_pkg;

  `include "lockstep_consts.svh"

  typedef logic [`LS_ADDR_W-1:0]   wb_addr_t;    // Byte address
  typedef logic [`LS_DATA_W-1:0]   wb_data_t;
  typedef logic [`LS_ERRCNT_W-1:0] err_count_t;  // Detected mismatches

  // Master to slave, 67 bits
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
  } wb_req_t;

  // Slave to master, 33 bits
  typedef struct packed {
    logic     ack;
    wb_data_t dat_r;
  } wb_rsp_t;

  typedef enum logic {
    CORE_FETCH = 1'b0,  // Burst of sequential reads
    CORE_STORE = 1'b1   // Write of the running sum
  } core_state_e;

endpackage

//--- hw/lockstep_core.sv
/*
 * Lockstep core
 * Reads consecutive words over Wishbone classic, accumulates them and
 * stores the running sum after every burst. Setback restarts at boot
 */

`timescale 1ns/1ps
`include "lockstep_consts.svh"

module lockstep_core (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   setback_i,
  input  lockstep_pkg::wb_addr_t boot_addr_i,
  input  lockstep_pkg::wb_rsp_t  wb_rsp_i,
  output lockstep_pkg::wb_req_t  wb_req_o
);

  localparam int unsigned burst_cnt_w = $clog2(`LS_BURST_LEN + 1);
  localparam logic [burst_cnt_w-1:0] burst_last = burst_cnt_w'(`LS_BURST_LEN - 1);

  lockstep_pkg::core_state_e state_q;
  lockstep_pkg::core_state_e state_d;
  lockstep_pkg::wb_addr_t    addr_q;       // Next read address
  lockstep_pkg::wb_data_t    acc_q;        // Running sum since restart
  logic [burst_cnt_w-1:0]    burst_q;      // Reads done in this burst
  logic                      active_q;     // Request on the bus
  logic                      restart;
  logic                      ack;
  logic                      fetch_ack;
  logic                      store_ack;

  assign restart   = reset_i | setback_i;  // Both bring the core to boot state
  assign ack       = active_q & wb_rsp_i.ack;
  assign fetch_ack = ack & (state_q == lockstep_pkg::CORE_FETCH);
  assign store_ack = ack & (state_q == lockstep_pkg::CORE_STORE);

  // Program sequencing
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lockstep_pkg::CORE_FETCH: begin
        if (fetch_ack && (burst_q == burst_last)) begin
          state_d = lockstep_pkg::CORE_STORE;
        end
      end
      lockstep_pkg::CORE_STORE: begin
        if (store_ack) begin
          state_d = lockstep_pkg::CORE_FETCH;
        end
      end
      default: begin
        state_d = lockstep_pkg::CORE_FETCH;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (restart) begin
      state_q <= lockstep_pkg::CORE_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // One idle cycle follows every ack
  always_ff @(posedge clk_i) begin
    if (restart) begin
      active_q <= 1'b0;
    end else if (ack) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // Boot address is sampled on every restart
  always_ff @(posedge clk_i) begin
    if (restart) begin
      addr_q <= boot_addr_i;
    end else if (fetch_ack) begin
      addr_q <= addr_q + lockstep_pkg::wb_addr_t'(4);
    end
  end

  always_ff @(posedge clk_i) begin
    if (restart) begin
      acc_q <= '0;
    end else if (fetch_ack) begin
      acc_q <= acc_q + wb_rsp_i.dat_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (restart) begin
      burst_q <= '0;
    end else if (fetch_ack) begin
      if (burst_q == burst_last) begin
        burst_q <= '0;
      end else begin
        burst_q <= burst_q + 1'b1;
      end
    end
  end

  // Bus request follows state and address register
  always_comb begin
    wb_req_o     = '0;
    wb_req_o.cyc = active_q;
    wb_req_o.stb = active_q;
    wb_req_o.we  = active_q & (state_q == lockstep_pkg::CORE_STORE);
    if (state_q == lockstep_pkg::CORE_STORE) begin
      wb_req_o.adr = lockstep_pkg::wb_addr_t'(`LS_RESULT_ADDR);
    end else begin
      wb_req_o.adr = addr_q;
    end
    // Sum kept on dat_w so a diverged accumulator shows up at once
    wb_req_o.dat_w = acc_q;
  end

  a_store_to_result: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wb_req_o.we |-> (wb_req_o.adr == lockstep_pkg::wb_addr_t'(`LS_RESULT_ADDR))
  ) else $error("core write outside result address");

endmodule

//--- hw/dmr_unit.sv
/*
 * DMR unit
 * Compares the two core requests every cycle, forwards core 0 on a match,
 * blocks and flags on a mismatch, sets both cores back and counts errors.
 * Optional bit flip on core 1 read data for fault injection
 */

`timescale 1ns/1ps

module dmr_unit (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         fault_inject_i,
  input  lockstep_pkg::wb_req_t  [1:0] core_req_i,
  output lockstep_pkg::wb_rsp_t  [1:0] core_rsp_o,
  input  lockstep_pkg::wb_rsp_t        sys_rsp_i,
  output lockstep_pkg::wb_req_t        sys_req_o,
  output logic                         core_setback_o,
  output logic                         dmr_error_o,
  output lockstep_pkg::err_count_t     err_count_o
);

  logic                     mismatch;
  logic                     detect;       // New error, not the setback echo
  logic                     block;
  logic                     error_q;
  logic                     inject_armed_q;
  logic                     read_ack;
  logic                     inject_hit;
  lockstep_pkg::err_count_t err_count_q;

  // Full request compare, payload included
  assign mismatch = (core_req_i[0] != core_req_i[1]);

  // Cores still show the fault while the setback is applied
  assign detect = mismatch & ~error_q;
  assign block  = mismatch | error_q;

  always_comb begin
    sys_req_o = core_req_i[0];
    if (block) begin
      sys_req_o.cyc = 1'b0;
      sys_req_o.stb = 1'b0;
    end
  end

  // Acked read actually seen by the bus
  assign read_ack   = sys_req_o.cyc & sys_req_o.stb & ~sys_req_o.we & sys_rsp_i.ack;
  assign inject_hit = inject_armed_q & read_ack;

  // Response fan-out
  always_comb begin
    core_rsp_o[0]       = sys_rsp_i;
    core_rsp_o[1]       = sys_rsp_i;
    core_rsp_o[1].dat_r = sys_rsp_i.dat_r ^ lockstep_pkg::wb_data_t'(inject_hit); // Bit 0 flip
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inject_armed_q <= 1'b0;
    end else if (fault_inject_i) begin
      inject_armed_q <= 1'b1;
    end else if (inject_hit) begin
      inject_armed_q <= 1'b0;
    end
  end

  // Single-cycle error pulse, doubles as setback
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      error_q <= 1'b0;
    end else begin
      error_q <= detect;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_count_q <= '0;
    end else if (detect && (err_count_q != '1)) begin
      err_count_q <= err_count_q + 1'b1;  // Saturating
    end
  end

  assign dmr_error_o    = error_q;
  assign core_setback_o = error_q;
  assign err_count_o    = err_count_q;

  a_no_stb_on_mismatch: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mismatch |-> !sys_req_o.stb
  ) else $error("diverged request reached the bus");

  // Cores must realign after one setback cycle
  a_setback_single: assert property (
    @(posedge clk_i) disable iff (reset_i)
    core_setback_o |=> !core_setback_o
  ) else $error("setback held for two cycles");

endmodule

//--- hw/lockstep_wrap.sv
/*
 * Lockstep wrapper
 * Two identical cores behind a DMR unit, bound to one Wishbone classic
 * system bus. Reports mismatches and their count
 */

`timescale 1ns/1ps

module lockstep_wrap (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fault_inject_i,
  input  lockstep_pkg::wb_addr_t   boot_addr_i,
  input  lockstep_pkg::wb_rsp_t    wb_rsp_i,
  output lockstep_pkg::wb_req_t    wb_req_o,
  output logic                     dmr_error_o,
  output lockstep_pkg::err_count_t err_count_o
);

  lockstep_pkg::wb_req_t [1:0] core2dmr;      // Requests from the cores
  lockstep_pkg::wb_rsp_t [1:0] dmr2core;      // Responses to the cores
  logic                        core_setback;  // Shared by both cores

  // Same boot address for both, lockstep needs identical state
  for (genvar i = 0; i < 2; i++) begin : gen_cores
    lockstep_core i_core (
      .clk_i       ( clk_i        ),
      .reset_i     ( reset_i      ),
      .setback_i   ( core_setback ),
      .boot_addr_i ( boot_addr_i  ),
      .wb_rsp_i    ( dmr2core[i]  ),
      .wb_req_o    ( core2dmr[i]  )
    );
  end

  dmr_unit i_dmr_unit (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fault_inject_i ( fault_inject_i ),
    .core_req_i     ( core2dmr       ),
    .core_rsp_o     ( dmr2core       ),
    .sys_rsp_i      ( wb_rsp_i       ),  // System response in
    .sys_req_o      ( wb_req_o       ),  // Checked request out
    .core_setback_o ( core_setback   ),
    .dmr_error_o    ( dmr_error_o    ),
    .err_count_o    ( err_count_o    )
  );

endmodule

//--- tb/wb_mem_model.sv
/*
 * Wishbone classic memory model for the lockstep testbench
 * Random 0 to 3 wait states, read data derived from the address,
 * writes are acked and dropped
 */

`timescale 1ns/1ps

module wb_mem_model (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  lockstep_pkg::wb_req_t wb_req_i,
  output lockstep_pkg::wb_rsp_t wb_rsp_o
);

  localparam logic [31:0]            rand_seed = 32'h58dad625;
  localparam lockstep_pkg::wb_data_t data_mult = 32'h9E3779B1;  // Golden-ratio hash

  logic [1:0] wait_left;  // Cycles still to wait before ack
  logic       req;

  assign req = wb_req_i.cyc & wb_req_i.stb;

  // Ack only while a request is on the bus
  always_comb begin
    wb_rsp_o.ack   = req & (wait_left == 2'd0);
    wb_rsp_o.dat_r = '0;
    if (req && !wb_req_i.we) begin
      wb_rsp_o.dat_r = wb_req_i.adr * data_mult;
    end
  end

  // Wait states drawn in this process, which owns the seed
  initial begin
    void'($urandom(rand_seed));
    wait_left = 2'($urandom_range(3, 0));
    forever begin
      @(posedge clk_i);
      if (!reset_i && req) begin
        if (wait_left == 2'd0) begin
          wait_left <= 2'($urandom_range(3, 0));  // Next transaction
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

endmodule

//--- tb/tb_lockstep_wrap.sv
/*
 * Testbench for the lockstep wrapper
 * Runs the cores against a memory model with wait states, checks reads,
 * stored sums and bus stability, and injects faults into core 1
 */

`timescale 1ns/1ps
`include "lockstep_consts.svh"

module tb_lockstep_wrap;

  localparam lockstep_pkg::wb_addr_t boot_addr  = 32'h0000_0200;
  localparam lockstep_pkg::wb_data_t data_mult  = 32'h9E3779B1;
  localparam int unsigned            n_inject   = 4;
  // 40 stores of 5 transactions, each at most 5 cycles
  localparam int unsigned            max_cycles = 40 * 5 * 5 + 200;

  logic                     clk_i;
  logic                     reset_i;
  logic                     fault_inject_i;
  lockstep_pkg::wb_addr_t   boot_addr_i;
  lockstep_pkg::wb_rsp_t    wb_rsp_i;
  lockstep_pkg::wb_req_t    wb_req_o;
  logic                     dmr_error_o;
  lockstep_pkg::err_count_t err_count_o;

  // Bus tracking state, written only by the compare process
  lockstep_pkg::wb_addr_t exp_addr;
  lockstep_pkg::wb_req_t  prev_req;
  logic                   prev_pending;   // Request seen without ack
  logic                   ack_now;
  logic                   armed_ref;      // Injection armed, mirror of the DUT
  logic                   corrupted;      // Core 1 got a flipped read
  int unsigned            hit_age;        // Edges since the flipped read
  int unsigned            stores;         // Stores since last restart
  int unsigned            reads_in_burst;
  int unsigned            read_acks;
  int unsigned            errors_seen;
  int unsigned            cycles;

  lockstep_wrap lockstep_wrap_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fault_inject_i ( fault_inject_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .wb_rsp_i       ( wb_rsp_i       ),
    .wb_req_o       ( wb_req_o       ),
    .dmr_error_o    ( dmr_error_o    ),
    .err_count_o    ( err_count_o    )
  );

  wb_mem_model i_mem (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .wb_req_i ( wb_req_o ),
    .wb_rsp_o ( wb_rsp_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // Expected sum stored after burst number store_idx since restart
  function automatic lockstep_pkg::wb_data_t ref_sum(input lockstep_pkg::wb_addr_t boot,
                                                     input int unsigned store_idx);
    lockstep_pkg::wb_data_t sum;
    lockstep_pkg::wb_addr_t addr;
    int unsigned            n_reads;
    int unsigned            i;
    sum     = '0;
    n_reads = (store_idx + 1) * `LS_BURST_LEN;
    for (i = 0; i < n_reads; i++) begin
      addr = boot + lockstep_pkg::wb_addr_t'(4 * i);
      sum  = sum + addr * data_mult;
    end
    return sum;
  endfunction

  // One bus sample, taken at the rising edge before any update
  task automatic track_bus();
    ack_now = wb_req_o.cyc & wb_req_o.stb & wb_rsp_i.ack;
    if (prev_pending) begin
      check_value(wb_req_o, prev_req, "request changed while waiting for ack");
    end

    // Error pulse is due two edges after the flipped read
    if (corrupted) begin
      hit_age++;
      check_value(dmr_error_o, hit_age == 2, "dmr_error_o pulse timing");
    end else begin
      check_value(dmr_error_o, 1'b0, "dmr_error_o without injected fault");
    end
    if (dmr_error_o) begin
      errors_seen++;
      corrupted      = 1'b0;
      exp_addr       = boot_addr;
      stores         = 0;
      reads_in_burst = 0;
    end
    check_value(err_count_o, errors_seen, "err_count_o");

    if (ack_now) begin
      check_value(corrupted, 1'b0, "bus access between flipped read and error pulse");
      if (wb_req_o.we) begin
        check_value(wb_req_o.adr, `LS_RESULT_ADDR, "store address");
        check_value(reads_in_burst, `LS_BURST_LEN, "reads before store");
        check_value(wb_req_o.dat_w, ref_sum(boot_addr, stores), "stored sum");
        stores++;
        reads_in_burst = 0;
      end else begin
        check_value(reads_in_burst < `LS_BURST_LEN, 1'b1, "read where a store was due");
        check_value(wb_req_o.adr, exp_addr, "read address");
        exp_addr = exp_addr + 4;
        reads_in_burst++;
        read_acks++;
        if (armed_ref) begin
          armed_ref = 1'b0;
          corrupted = 1'b1;
          hit_age   = 0;
        end
      end
    end

    if (fault_inject_i) begin
      armed_ref = 1'b1;  // Takes effect from the next ack
    end
    prev_pending = wb_req_o.cyc & wb_req_o.stb & ~ack_now;
    prev_req     = wb_req_o;
  endtask

  initial begin
    exp_addr       = boot_addr;
    prev_req       = '0;
    prev_pending   = 1'b0;
    ack_now        = 1'b0;
    armed_ref      = 1'b0;
    corrupted      = 1'b0;
    hit_age        = 0;
    stores         = 0;
    reads_in_burst = 0;
    read_acks      = 0;
    errors_seen    = 0;
    forever begin
      @(posedge clk_i);
      if (!reset_i) begin
        track_bus();
      end
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles <= max_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", max_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  // Stimulus, driven on falling edges
  initial begin
    int unsigned k;
    int unsigned rd_mark;
    reset_i        = 1'b1;
    fault_inject_i = 1'b0;
    boot_addr_i    = boot_addr;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    @(posedge clk_i);
    check_value(wb_req_o.cyc, 1'b0, "cyc after reset");
    check_value(dmr_error_o, 1'b0, "dmr_error_o after reset");
    check_value(err_count_o, 0, "err_count_o after reset");
    @(posedge clk_i);
    check_value(wb_req_o.cyc, 1'b1, "first read after reset");

    wait (stores >= 12);  // Fault-free stretch

    // Injections at each position inside a burst
    for (k = 0; k < n_inject; k++) begin
      rd_mark = read_acks;
      wait (read_acks >= rd_mark + (k % `LS_BURST_LEN));
      @(negedge clk_i);
      fault_inject_i = 1'b1;
      @(negedge clk_i);
      fault_inject_i = 1'b0;
      wait (errors_seen == k + 1);
      wait (stores >= 3);
    end

    @(posedge clk_i);
    check_value(err_count_o, n_inject, "final error count");
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- lockstep_wrap.f
+incdir+include
hw/lockstep_pkg.sv
hw/lockstep_core.sv
hw/dmr_unit.sv
hw/lockstep_wrap.sv
tb/wb_mem_model.sv
tb/tb_lockstep_wrap.sv
